// File: design/alu_pkg.sv
`default_nettype none

package alu_pkg;

    localparam int data_w = 32;
    localparam int sa_w   = 5;

    typedef enum logic [4:0] {
        op_and    = 5'd0,
        op_or     = 5'd1,
        op_nor    = 5'd2,
        op_xor    = 5'd3,
        op_add    = 5'd4,
        op_addu   = 5'd5,
        op_sub    = 5'd6,
        op_subu   = 5'd7,
        op_slt    = 5'd8,
        op_sltu   = 5'd9,
        op_sll    = 5'd10, // shift by src_a[4:0]
        op_srl    = 5'd11,
        op_sra    = 5'd12,
        op_sll_sa = 5'd13, // shift by sa register
        op_srl_sa = 5'd14,
        op_sra_sa = 5'd15,
        op_lui    = 5'd16,
        op_pass   = 5'd17,
        op_mult   = 5'd18,
        op_multu  = 5'd19,
        op_div    = 5'd20,
        op_divu   = 5'd21,
        op_mthi   = 5'd22,
        op_mtlo   = 5'd23
    } alu_op_t;

    typedef enum logic [1:0] {
        idle = 2'd0,
        run  = 2'd1,
        done = 2'd2  // fix-up cycle
    } div_state_t;

endpackage

`default_nettype wire

// File: design/apb_map_pkg.sv
`default_nettype none

package apb_map_pkg;

    localparam int addr_w = 6;

    localparam logic [addr_w-1:0] reg_src_a  = 6'h00;
    localparam logic [addr_w-1:0] reg_src_b  = 6'h04;
    localparam logic [addr_w-1:0] reg_sa     = 6'h08;
    localparam logic [addr_w-1:0] reg_ctrl   = 6'h0C;
    localparam logic [addr_w-1:0] reg_status = 6'h10; // read only
    localparam logic [addr_w-1:0] reg_result = 6'h14;
    localparam logic [addr_w-1:0] reg_hi     = 6'h18;
    localparam logic [addr_w-1:0] reg_lo     = 6'h1C;

    localparam int ctrl_op_msb     = 4;  // opcode in ctrl[4:0]
    localparam int ctrl_abort_bit  = 31;
    localparam int status_busy_bit = 0;
    localparam int status_ovf_bit  = 1;

endpackage

`default_nettype wire

// File: design/div_radix2.sv
`timescale 1ns/1ns
`default_nettype none

module div_radix2 (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       start,
    input  wire logic                       abort,
    input  wire logic                       sign,
    input  wire logic [alu_pkg::data_w-1:0] dividend,
    input  wire logic [alu_pkg::data_w-1:0] divisor,
    output logic                            done,
    output logic      [alu_pkg::data_w-1:0] quotient,
    output logic      [alu_pkg::data_w-1:0] remainder
);

    localparam int dw = alu_pkg::data_w;

    alu_pkg::div_state_t state;
    logic [4:0]          step;
    logic [dw-1:0]       quo;       // dividend shifts out, quotient bits in
    logic [dw-1:0]       rem;
    logic [dw-1:0]       den;
    logic                neg_q;
    logic                neg_r;
    logic [dw:0]         rem_shift;
    logic [dw:0]         trial;

    assign rem_shift = {rem, quo[dw-1]};
    assign trial     = rem_shift - {1'b0, den};

    always_ff @(posedge clk) begin
        if (!rst_n || abort) begin
            state <= alu_pkg::idle;
            step  <= '0;
        end else if (start) begin
            state <= alu_pkg::run;
            step  <= '0;
            quo   <= (sign && dividend[dw-1]) ? -dividend : dividend;
            den   <= (sign && divisor[dw-1]) ? -divisor : divisor;
            rem   <= '0;
            neg_q <= sign && (dividend[dw-1] ^ divisor[dw-1]);
            neg_r <= sign && dividend[dw-1];
        end else if (state == alu_pkg::run) begin
            rem  <= trial[dw] ? rem_shift[dw-1:0] : trial[dw-1:0]; // restore on borrow
            quo  <= {quo[dw-2:0], ~trial[dw]};
            step <= step + 5'd1;
            if (step == 5'd31) begin
                state <= alu_pkg::done;
            end
        end else if (state == alu_pkg::done) begin
            state <= alu_pkg::idle;
        end
    end

    // sign fix-up
    assign done      = (state == alu_pkg::done);
    assign quotient  = neg_q ? -quo : quo;
    assign remainder = neg_r ? -rem : rem;

endmodule

`default_nettype wire

// File: design/alu_cmd_decode.sv
`timescale 1ns/1ns
`default_nettype none

module alu_cmd_decode (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [apb_map_pkg::addr_w-1:0] paddr,
    input  wire logic                           psel,
    input  wire logic                           penable,
    input  wire logic                           pwrite,
    input  wire logic [alu_pkg::data_w-1:0]     pwdata,
    input  wire logic                           busy,
    output logic                                pslverr,
    output logic      [alu_pkg::data_w-1:0]     src_a,
    output logic      [alu_pkg::data_w-1:0]     src_b,
    output logic      [alu_pkg::sa_w-1:0]       sa,
    output alu_pkg::alu_op_t                    op,
    output logic                                issue,
    output logic                                abort
);

    logic wr_access;
    logic ctrl_wr;
    logic abort_req;
    logic issue_req;
    logic writable;

    assign wr_access = psel && penable && pwrite;
    assign ctrl_wr   = wr_access && (paddr == apb_map_pkg::reg_ctrl);
    assign abort_req = ctrl_wr && pwdata[apb_map_pkg::ctrl_abort_bit];
    assign issue_req = ctrl_wr && !pwdata[apb_map_pkg::ctrl_abort_bit] && !busy;

    always_comb begin
        case (paddr)
            apb_map_pkg::reg_src_a,
            apb_map_pkg::reg_src_b,
            apb_map_pkg::reg_sa,
            apb_map_pkg::reg_ctrl: writable = 1'b1;
            default:               writable = 1'b0;
        endcase
    end

    // refused issue while busy, or write to read-only/unmapped offset
    assign pslverr = (ctrl_wr && !abort_req && busy) || (wr_access && !writable);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            src_a <= '0;
            src_b <= '0;
            sa    <= '0;
            op    <= alu_pkg::op_and;
            issue <= 1'b0;
            abort <= 1'b0;
        end else begin
            issue <= issue_req; // one cycle pulses
            abort <= abort_req;
            if (wr_access && paddr == apb_map_pkg::reg_src_a) begin
                src_a <= pwdata;
            end
            if (wr_access && paddr == apb_map_pkg::reg_src_b) begin
                src_b <= pwdata;
            end
            if (wr_access && paddr == apb_map_pkg::reg_sa) begin
                sa <= pwdata[alu_pkg::sa_w-1:0];
            end
            if (issue_req) begin
                op <= alu_pkg::alu_op_t'(pwdata[apb_map_pkg::ctrl_op_msb:0]);
            end
        end
    end

endmodule

`default_nettype wire

// File: design/alu_execute.sv
`timescale 1ns/1ns
`default_nettype none

module alu_execute #(
    parameter int mult_stages = 3
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic [alu_pkg::data_w-1:0] src_a,
    input  wire logic [alu_pkg::data_w-1:0] src_b,
    input  wire logic [alu_pkg::sa_w-1:0]   sa,
    input  wire alu_pkg::alu_op_t           op,
    input  wire logic                       issue,
    input  wire logic                       abort,
    output logic                            busy,
    output logic                            wr_result,
    output logic      [alu_pkg::data_w-1:0] result_val,
    output logic                            ovf_val,
    output logic                            wr_hi,
    output logic      [alu_pkg::data_w-1:0] hi_val,
    output logic                            wr_lo,
    output logic      [alu_pkg::data_w-1:0] lo_val
);

    localparam int dw = alu_pkg::data_w;

    logic [dw:0]            sum_ext;
    logic [dw:0]            diff_ext;
    logic                   is_mult;
    logic                   is_div;
    logic                   mult_sign;
    logic [2*dw-1:0]        mult_a;
    logic [2*dw-1:0]        mult_b;
    logic [2*dw-1:0]        prod_pipe [mult_stages];
    logic [mult_stages-1:0] mult_vld;
    logic                   mult_out;
    logic                   div_done;
    logic                   div_fin;
    logic [dw-1:0]          quotient;
    logic [dw-1:0]          remainder;
    alu_pkg::div_state_t    seq;

    assign sum_ext  = {src_a[dw-1], src_a} + {src_b[dw-1], src_b};
    assign diff_ext = {src_a[dw-1], src_a} - {src_b[dw-1], src_b};

    always_comb begin
        result_val = '0;
        ovf_val    = 1'b0;
        case (op)
            alu_pkg::op_and:    result_val = src_a & src_b;
            alu_pkg::op_or:     result_val = src_a | src_b;
            alu_pkg::op_nor:    result_val = ~(src_a | src_b);
            alu_pkg::op_xor:    result_val = src_a ^ src_b;
            alu_pkg::op_add: begin
                result_val = sum_ext[dw-1:0];
                ovf_val    = sum_ext[dw] ^ sum_ext[dw-1];
            end
            alu_pkg::op_addu:   result_val = src_a + src_b;
            alu_pkg::op_sub: begin
                result_val = diff_ext[dw-1:0];
                ovf_val    = diff_ext[dw] ^ diff_ext[dw-1];
            end
            alu_pkg::op_subu:   result_val = src_a - src_b;
            alu_pkg::op_slt:    result_val = dw'($signed(src_a) < $signed(src_b));
            alu_pkg::op_sltu:   result_val = dw'(src_a < src_b);
            alu_pkg::op_sll:    result_val = src_b << src_a[4:0];
            alu_pkg::op_srl:    result_val = src_b >> src_a[4:0];
            alu_pkg::op_sra:    result_val = $signed(src_b) >>> src_a[4:0];
            alu_pkg::op_sll_sa: result_val = src_b << sa;
            alu_pkg::op_srl_sa: result_val = src_b >> sa;
            alu_pkg::op_sra_sa: result_val = $signed(src_b) >>> sa;
            alu_pkg::op_lui:    result_val = {src_b[15:0], 16'b0};
            alu_pkg::op_pass:   result_val = src_a;
            default:            result_val = '0;
        endcase
    end

    assign is_mult   = (op == alu_pkg::op_mult) || (op == alu_pkg::op_multu);
    assign is_div    = (op == alu_pkg::op_div) || (op == alu_pkg::op_divu);
    assign mult_sign = (op == alu_pkg::op_mult);
    assign wr_result = issue && !is_mult && !is_div
                       && op != alu_pkg::op_mthi && op != alu_pkg::op_mtlo;

    // sign extension makes the low 64 bits correct for both forms
    assign mult_a = {{dw{mult_sign & src_a[dw-1]}}, src_a};
    assign mult_b = {{dw{mult_sign & src_b[dw-1]}}, src_b};

    always_ff @(posedge clk) begin
        if (issue && is_mult) begin
            prod_pipe[0] <= mult_a * mult_b;
        end
        for (int i = 1; i < mult_stages; i++) begin
            prod_pipe[i] <= prod_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || abort) begin
            mult_vld <= '0;
        end else begin
            mult_vld[0] <= issue && is_mult;
            for (int i = 1; i < mult_stages; i++) begin
                mult_vld[i] <= mult_vld[i-1];
            end
        end
    end

    div_radix2 div_radix2_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (issue && is_div),
        .abort     (abort),
        .sign      (op == alu_pkg::op_div),
        .dividend  (src_a),
        .divisor   (src_b),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    assign mult_out = mult_vld[mult_stages-1] && !abort;
    assign div_fin  = div_done && !abort;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            seq <= alu_pkg::idle;
        end else if (abort) begin
            seq <= alu_pkg::idle;
        end else if (issue && (is_mult || is_div)) begin
            seq <= alu_pkg::run;
        end else if (mult_out || div_fin) begin
            seq <= alu_pkg::idle;
        end
    end

    assign busy = (seq == alu_pkg::run);

    assign wr_hi  = (issue && op == alu_pkg::op_mthi) || mult_out || div_fin;
    assign wr_lo  = (issue && op == alu_pkg::op_mtlo) || mult_out || div_fin;
    assign hi_val = mult_out ? prod_pipe[mult_stages-1][2*dw-1:dw] :
                    div_fin  ? remainder : src_a;
    assign lo_val = mult_out ? prod_pipe[mult_stages-1][dw-1:0] :
                    div_fin  ? quotient : src_a;

endmodule

`default_nettype wire

// File: design/alu_result.sv
`timescale 1ns/1ns
`default_nettype none

module alu_result (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [apb_map_pkg::addr_w-1:0] paddr,
    input  wire logic                           psel,
    input  wire logic                           busy,
    input  wire logic                           wr_result,
    input  wire logic [alu_pkg::data_w-1:0]     result_val,
    input  wire logic                           ovf_val,
    input  wire logic                           wr_hi,
    input  wire logic [alu_pkg::data_w-1:0]     hi_val,
    input  wire logic                           wr_lo,
    input  wire logic [alu_pkg::data_w-1:0]     lo_val,
    input  wire logic [alu_pkg::data_w-1:0]     src_a,
    input  wire logic [alu_pkg::data_w-1:0]     src_b,
    input  wire logic [alu_pkg::sa_w-1:0]       sa,
    input  wire alu_pkg::alu_op_t               op,
    output logic      [alu_pkg::data_w-1:0]     prdata
);

    logic [alu_pkg::data_w-1:0] result_q;
    logic [alu_pkg::data_w-1:0] hi_q;
    logic [alu_pkg::data_w-1:0] lo_q;
    logic                       ovf_q;
    logic [alu_pkg::data_w-1:0] status;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q <= '0;
            ovf_q    <= 1'b0;
            hi_q     <= '0;
            lo_q     <= '0;
        end else begin
            if (wr_result) begin
                result_q <= result_val;
                ovf_q    <= ovf_val; // every simple op refreshes the flag
            end
            if (wr_hi) begin
                hi_q <= hi_val;
            end
            if (wr_lo) begin
                lo_q <= lo_val;
            end
        end
    end

    always_comb begin
        status = '0;
        status[apb_map_pkg::status_busy_bit] = busy;
        status[apb_map_pkg::status_ovf_bit]  = ovf_q;
    end

    always_comb begin
        prdata = '0;
        if (psel) begin
            case (paddr)
                apb_map_pkg::reg_src_a:  prdata = src_a;
                apb_map_pkg::reg_src_b:  prdata = src_b;
                apb_map_pkg::reg_sa:     prdata = alu_pkg::data_w'(sa);
                apb_map_pkg::reg_ctrl:   prdata = alu_pkg::data_w'(op); // opcode only
                apb_map_pkg::reg_status: prdata = status;
                apb_map_pkg::reg_result: prdata = result_q;
                apb_map_pkg::reg_hi:     prdata = hi_q;
                apb_map_pkg::reg_lo:     prdata = lo_q;
                default:                 prdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/alu_unit_top.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit_top #(
    parameter int mult_stages = 3
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic [apb_map_pkg::addr_w-1:0] paddr,
    input  wire logic                           psel,
    input  wire logic                           penable,
    input  wire logic                           pwrite,
    input  wire logic [alu_pkg::data_w-1:0]     pwdata,
    output logic      [alu_pkg::data_w-1:0]     prdata,
    output logic                                pready,
    output logic                                pslverr
);

    logic [alu_pkg::data_w-1:0] src_a;
    logic [alu_pkg::data_w-1:0] src_b;
    logic [alu_pkg::sa_w-1:0]   sa;
    alu_pkg::alu_op_t           op;
    logic                       issue;
    logic                       abort;
    logic                       busy;
    logic                       wr_result;
    logic [alu_pkg::data_w-1:0] result_val;
    logic                       ovf_val;
    logic                       wr_hi;
    logic [alu_pkg::data_w-1:0] hi_val;
    logic                       wr_lo;
    logic [alu_pkg::data_w-1:0] lo_val;

    assign pready = 1'b1; // no wait states

    alu_cmd_decode alu_cmd_decode_i (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .busy(busy), .pslverr(pslverr),
        .src_a(src_a), .src_b(src_b), .sa(sa), .op(op), .issue(issue), .abort(abort)
    );

    alu_execute #(.mult_stages(mult_stages)) alu_execute_i (
        .clk(clk), .rst_n(rst_n), .src_a(src_a), .src_b(src_b), .sa(sa), .op(op),
        .issue(issue), .abort(abort), .busy(busy), .wr_result(wr_result),
        .result_val(result_val), .ovf_val(ovf_val), .wr_hi(wr_hi), .hi_val(hi_val),
        .wr_lo(wr_lo), .lo_val(lo_val)
    );

    alu_result alu_result_i (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .busy(busy),
        .wr_result(wr_result), .result_val(result_val), .ovf_val(ovf_val),
        .wr_hi(wr_hi), .hi_val(hi_val), .wr_lo(wr_lo), .lo_val(lo_val),
        .src_a(src_a), .src_b(src_b), .sa(sa), .op(op), .prdata(prdata)
    );

endmodule

`default_nettype wire

// File: dv/alu_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module alu_unit_tb;

    localparam int n_pat    = 37;
    localparam int n_random = 20;
    localparam int poll_max = 100;

    logic                           clk;
    logic                           rst_n;
    logic [apb_map_pkg::addr_w-1:0] paddr;
    logic                           psel;
    logic                           penable;
    logic                           pwrite;
    logic [31:0]                    pwdata;
    logic [31:0]                    prdata;
    logic                           pready;
    logic                           pslverr;

    logic [31:0] pat_mem [0:8*n_pat-1]; // 8 words per case
    int          errors;
    int          cases;
    logic [31:0] exp_result;
    logic [31:0] exp_hi;
    logic [31:0] exp_lo;
    logic        exp_ovf;

    alu_unit_top alu_unit_top_i (
        .clk(clk), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("FAIL t=%0t %s expected %h read %h", $time, name, expected, actual);
    endtask

    // setup then access phase with sampling mid access before the completing edge
    task automatic apb_xfer(input logic [5:0] addr, input logic wr, input logic [31:0] data,
                            output logic [31:0] rdata, output logic err);
        @(negedge clk);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #10;
        rdata = prdata;
        err   = pslverr;
        if (pready !== 1'b1) begin
            errors++;
            $display("pready was low during an APB access at %0t", $time);
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [5:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rd;
        logic        err;
        apb_xfer(addr, 1'b1, data, rd, err);
        if (err !== exp_err) report_mismatch("pslverr", 32'(exp_err), 32'(err));
    endtask

    task automatic read_reg(input logic [5:0] addr, output logic [31:0] data);
        logic err;
        apb_xfer(addr, 1'b0, 32'h0, data, err);
        if (err !== 1'b0) report_mismatch("pslverr", 32'h0, 32'(err));
    endtask

    task automatic wait_idle();
        logic [31:0] status;
        int          polls;
        polls = 0;
        do begin
            read_reg(apb_map_pkg::reg_status, status);
            polls++;
        end while (status[apb_map_pkg::status_busy_bit] && polls < poll_max);
        if (status[apb_map_pkg::status_busy_bit]) begin
            errors++;
            $display("timeout at %0t, busy still set after %0d STATUS reads", $time, poll_max);
        end
    endtask

    task automatic check_regs();
        logic [31:0] rd;
        logic [31:0] exp_status;
        exp_status = '0;
        exp_status[apb_map_pkg::status_ovf_bit] = exp_ovf;
        read_reg(apb_map_pkg::reg_result, rd);
        if (rd !== exp_result) report_mismatch("RESULT", exp_result, rd);
        read_reg(apb_map_pkg::reg_hi, rd);
        if (rd !== exp_hi) report_mismatch("HI", exp_hi, rd);
        read_reg(apb_map_pkg::reg_lo, rd);
        if (rd !== exp_lo) report_mismatch("LO", exp_lo, rd);
        read_reg(apb_map_pkg::reg_status, rd);
        if (rd !== exp_status) report_mismatch("STATUS", exp_status, rd);
    endtask

    task automatic run_op(input logic [31:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] sa);
        write_reg(apb_map_pkg::reg_src_a, a, 1'b0);
        write_reg(apb_map_pkg::reg_src_b, b, 1'b0);
        write_reg(apb_map_pkg::reg_sa, sa, 1'b0);
        write_reg(apb_map_pkg::reg_ctrl, op, 1'b0);
        wait_idle();
        check_regs();
        cases++;
    endtask

    // returns {remainder, quotient} where divide by zero gives all ones before the sign fix
    function automatic logic [63:0] div_model(input logic sgn, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] ma;
        logic [31:0] mb;
        logic [31:0] q;
        logic [31:0] r;
        ma = (sgn && a[31]) ? -a : a;
        mb = (sgn && b[31]) ? -b : b;
        if (mb == 32'h0) begin
            q = '1;
            r = ma;
        end else begin
            q = ma / mb;
            r = ma % mb;
        end
        if (sgn && (a[31] ^ b[31])) q = -q;
        if (sgn && a[31]) r = -r; // remainder follows the dividend
        return {r, q};
    endfunction

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] op;
        logic [31:0] rd;
        clk     = 1'b0;
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        errors  = 0;
        cases   = 0;
        void'($urandom(17603));
        $readmemh("dv/alu_patterns.txt", pat_mem);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < n_pat; i++) begin
            exp_result = pat_mem[8*i+4];
            exp_hi     = pat_mem[8*i+5];
            exp_lo     = pat_mem[8*i+6];
            exp_ovf    = pat_mem[8*i+7][0];
            run_op(pat_mem[8*i], pat_mem[8*i+1], pat_mem[8*i+2], pat_mem[8*i+3]);
        end

        // random divides keep result and flag from the last table row
        for (int i = 0; i < n_random; i++) begin
            a  = $urandom;
            b  = $urandom >> ($urandom % 32);
            op = ($urandom % 2 == 0) ? 32'(alu_pkg::op_div) : 32'(alu_pkg::op_divu);
            {exp_hi, exp_lo} = div_model(op == 32'(alu_pkg::op_div), a, b);
            run_op(op, a, b, 32'h0);
        end

        // writes refused while a divide runs
        a = 32'd1000;
        b = 32'd7;
        write_reg(apb_map_pkg::reg_src_a, a, 1'b0);
        write_reg(apb_map_pkg::reg_src_b, b, 1'b0);
        write_reg(apb_map_pkg::reg_ctrl, 32'(alu_pkg::op_divu), 1'b0);
        read_reg(apb_map_pkg::reg_status, rd);
        if (rd[apb_map_pkg::status_busy_bit] !== 1'b1) report_mismatch("STATUS", 32'h1, rd);
        write_reg(apb_map_pkg::reg_ctrl, 32'(alu_pkg::op_and), 1'b1);
        write_reg(apb_map_pkg::reg_status, 32'h3, 1'b1);
        wait_idle();
        read_reg(apb_map_pkg::reg_ctrl, rd);
        if (rd !== 32'(alu_pkg::op_divu)) report_mismatch("CTRL", 32'(alu_pkg::op_divu), rd);
        {exp_hi, exp_lo} = div_model(1'b0, a, b);
        check_regs();
        cases++;

        // abort keeps HI and LO from the divide above
        write_reg(apb_map_pkg::reg_src_a, 32'hFFFF0000, 1'b0);
        write_reg(apb_map_pkg::reg_src_b, 32'd3, 1'b0);
        write_reg(apb_map_pkg::reg_ctrl, 32'(alu_pkg::op_div), 1'b0);
        write_reg(apb_map_pkg::reg_ctrl, 32'h1 << apb_map_pkg::ctrl_abort_bit, 1'b0);
        read_reg(apb_map_pkg::reg_status, rd); // busy drops one edge after the abort
        if (rd[apb_map_pkg::status_busy_bit] !== 1'b0) report_mismatch("STATUS", 32'h0, rd);
        check_regs();
        cases++;
        {exp_hi, exp_lo} = div_model(1'b1, 32'hFFFFFF9C, 32'd9);
        run_op(32'(alu_pkg::op_div), 32'hFFFFFF9C, 32'd9, 32'h0);

        $display("cases run: %0d, errors: %0d", cases, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/alu_patterns.txt
// columns op src_a src_b sa then expected result hi lo ovf
// all fields hex with opcodes numbered as in alu_pkg
00 F0F0F0F0 FF00FF00 00 F000F000 00000000 00000000 0
01 F0F0F0F0 0F0F0000 00 FFFFF0F0 00000000 00000000 0
02 12345678 0000FFFF 00 EDCB0000 00000000 00000000 0
03 AAAAAAAA FFFF0000 00 5555AAAA 00000000 00000000 0
08 FFFFFFFF 00000001 00 00000001 00000000 00000000 0
09 FFFFFFFF 00000001 00 00000000 00000000 00000000 0
0A 00000024 8000000F 00 000000F0 00000000 00000000 0
0B 0000001F 80000000 00 00000001 00000000 00000000 0
0C 00000004 80000000 00 F8000000 00000000 00000000 0
0D 00000000 00000001 1F 80000000 00000000 00000000 0
0E 00000000 F0000000 08 00F00000 00000000 00000000 0
0F 00000000 F0000000 08 FFF00000 00000000 00000000 0
10 00000000 0000BEEF 00 BEEF0000 00000000 00000000 0
11 CAFEF00D 00000000 00 CAFEF00D 00000000 00000000 0
04 7FFFFFFF 00000001 00 80000000 00000000 00000000 1
05 7FFFFFFF 00000001 00 80000000 00000000 00000000 0
04 80000000 80000000 00 00000000 00000000 00000000 1
04 FFFFFFFF 00000001 00 00000000 00000000 00000000 0
06 80000000 00000001 00 7FFFFFFF 00000000 00000000 1
07 80000000 00000001 00 7FFFFFFF 00000000 00000000 0
06 7FFFFFFF FFFFFFFF 00 80000000 00000000 00000000 1
06 00000005 00000007 00 FFFFFFFE 00000000 00000000 0
12 FFFFFFFE 00000003 00 FFFFFFFE FFFFFFFF FFFFFFFA 0
13 FFFFFFFF FFFFFFFF 00 FFFFFFFE FFFFFFFE 00000001 0
12 80000000 80000000 00 FFFFFFFE 40000000 00000000 0
12 12345678 00010000 00 FFFFFFFE 00001234 56780000 0
13 80000000 00000002 00 FFFFFFFE 00000001 00000000 0
16 DEADBEEF 00000000 00 FFFFFFFE DEADBEEF 00000000 0
17 0BADC0DE 00000000 00 FFFFFFFE DEADBEEF 0BADC0DE 0
14 FFFFFFF9 00000002 00 FFFFFFFE FFFFFFFF FFFFFFFD 0
15 00000064 00000007 00 FFFFFFFE 00000002 0000000E 0
14 00000007 FFFFFFFE 00 FFFFFFFE 00000001 FFFFFFFD 0
15 12345678 00000000 00 FFFFFFFE 12345678 FFFFFFFF 0
14 FFFFFF00 00000000 00 FFFFFFFE FFFFFF00 00000001 0
14 00000010 00000000 00 FFFFFFFE 00000010 FFFFFFFF 0
14 80000000 FFFFFFFF 00 FFFFFFFE 00000000 80000000 0
15 FFFFFFF9 00000002 00 FFFFFFFE 00000001 7FFFFFFC 0

// File: vlog.f
design/alu_pkg.sv
design/apb_map_pkg.sv
design/div_radix2.sv
design/alu_cmd_decode.sv
design/alu_execute.sv
design/alu_result.sv
design/alu_unit_top.sv
dv/alu_unit_tb.sv

// File: Makefile
VERILATOR  := verilator
TOP        := alu_unit_tb
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$($(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
